// File: logic/pe_pkg.sv
package pe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_W      = 32;
    localparam int unsigned DATA_W      = 32;
    localparam int unsigned SEL_W       = DATA_W / 8;

    // Low address bits forwarded to the data memory
    localparam int unsigned DMEM_ADDR_W = 24;

    // Region code lives in the top address byte
    localparam int unsigned REGION_LSB  = 24;

    ////////////////////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////////////////////

    // 0x01xx_xxxx  data memory
    // 0x02xx_xxxx  RTC
    // 0x04xx_xxxx  PLIC
    // Any other code is unmapped and reads zero
    typedef enum logic [7:0] {
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04
    } region_e;

    // RTC word offsets, address bits 3:2
    typedef enum logic [1:0] {
        RTC_MTIME_LO    = 2'd0,
        RTC_MTIME_HI    = 2'd1,
        RTC_MTIMECMP_LO = 2'd2,
        RTC_MTIMECMP_HI = 2'd3
    } rtc_reg_e;

    // PLIC word offsets, address bits 3:2
    typedef enum logic [1:0] {
        PLIC_PENDING = 2'd0,
        PLIC_ENABLE  = 2'd1,
        PLIC_CLAIM   = 2'd2
    } plic_reg_e;

    ////////////////////////////////////////////////////////////////////////////
    // Peripheral constants
    ////////////////////////////////////////////////////////////////////////////

    // ID handed out by a successful claim
    localparam logic [DATA_W-1:0] PLIC_SRC_ID = 32'd1;

    // Compare value that never fires after reset
    localparam logic [2*DATA_W-1:0] MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage

// File: logic/pe_bus_decoder.sv
`timescale 1ns/1ps

module pe_bus_decoder (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    // Wishbone classic slave side
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [pe_pkg::SEL_W-1:0]         wb_sel_i,
    input  logic [pe_pkg::ADDR_W-1:0]        wb_adr_i,
    output logic                             wb_ack_o,
    output logic [pe_pkg::DATA_W-1:0]        wb_dat_o,

    // Peripheral strobes and read data
    output logic                             rtc_en_o,
    output logic                             plic_en_o,
    input  logic [pe_pkg::DATA_W-1:0]        rtc_rdata_i,
    input  logic [pe_pkg::DATA_W-1:0]        plic_rdata_i,

    // Data-memory port
    output logic                             dmem_en_o,
    output logic [pe_pkg::SEL_W-1:0]         dmem_we_o,
    output logic [pe_pkg::DMEM_ADDR_W-1:0]   dmem_addr_o,
    input  logic [pe_pkg::DATA_W-1:0]        dmem_data_i
);

    logic            accept;
    logic            ack_q;
    pe_pkg::region_e region_d;
    pe_pkg::region_e region_q;

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance and region decode
    ////////////////////////////////////////////////////////////////////////////

    // A new access is taken only while no ack is pending
    assign accept   = wb_cyc_i && wb_stb_i && !ack_q;

    assign region_d = pe_pkg::region_e'(wb_adr_i[pe_pkg::ADDR_W-1:pe_pkg::REGION_LSB]);

    assign dmem_en_o = accept && (region_d == pe_pkg::REGION_DMEM);
    assign rtc_en_o  = accept && (region_d == pe_pkg::REGION_RTC);
    assign plic_en_o = accept && (region_d == pe_pkg::REGION_PLIC);

    // Byte enables only on writes
    assign dmem_we_o   = wb_we_i ? wb_sel_i : '0;
    assign dmem_addr_o = wb_adr_i[pe_pkg::DMEM_ADDR_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Ack and return path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_q    <= 1'b0;
            region_q <= pe_pkg::REGION_DMEM;
        end else begin
            ack_q <= accept;
            // Remember where the data comes from in the ack cycle
            if (accept) begin
                region_q <= region_d;
            end
        end
    end

    assign wb_ack_o = ack_q;

    always_comb begin
        wb_dat_o = '0;
        if (ack_q) begin
            case (region_q)
                pe_pkg::REGION_DMEM: wb_dat_o = dmem_data_i;
                pe_pkg::REGION_RTC:  wb_dat_o = rtc_rdata_i;
                pe_pkg::REGION_PLIC: wb_dat_o = plic_rdata_i;
                // Unmapped regions read zero
                default:             wb_dat_o = '0;
            endcase
        end
    end

endmodule

// File: logic/pe_rtc.sv
`timescale 1ns/1ps

module pe_rtc (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        en_i,
    input  logic                        we_i,
    input  logic [pe_pkg::SEL_W-1:0]    sel_i,
    input  pe_pkg::rtc_reg_e            reg_i,
    input  logic [pe_pkg::DATA_W-1:0]   data_i,
    output logic [pe_pkg::DATA_W-1:0]   data_o,

    // Machine timer interrupt
    output logic                        mti_o
);

    logic [2*pe_pkg::DATA_W-1:0] mtime_q;
    logic [2*pe_pkg::DATA_W-1:0] mtimecmp_q;
    logic                        wr_cmp_lo;
    logic                        wr_cmp_hi;
    logic                        mti_q;

    ////////////////////////////////////////////////////////////////////////////
    // Counter and compare register
    ////////////////////////////////////////////////////////////////////////////

    // Writes to the mtime offsets fall through here and are dropped
    assign wr_cmp_lo = en_i && we_i && (reg_i == pe_pkg::RTC_MTIMECMP_LO);
    assign wr_cmp_hi = en_i && we_i && (reg_i == pe_pkg::RTC_MTIMECMP_HI);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= pe_pkg::MTIMECMP_RESET;
        end else begin
            for (int b = 0; b < pe_pkg::SEL_W; b++) begin
                if (sel_i[b] && wr_cmp_lo) begin
                    mtimecmp_q[b*8 +: 8] <= data_i[b*8 +: 8];
                end
                if (sel_i[b] && wr_cmp_hi) begin
                    mtimecmp_q[pe_pkg::DATA_W + b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data and interrupt
    ////////////////////////////////////////////////////////////////////////////

    // Sampled on the enable edge, presented during ack
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (reg_i)
                pe_pkg::RTC_MTIME_LO:    data_o <= mtime_q[pe_pkg::DATA_W-1:0];
                pe_pkg::RTC_MTIME_HI:    data_o <= mtime_q[2*pe_pkg::DATA_W-1:pe_pkg::DATA_W];
                pe_pkg::RTC_MTIMECMP_LO: data_o <= mtimecmp_q[pe_pkg::DATA_W-1:0];
                default: data_o <= mtimecmp_q[2*pe_pkg::DATA_W-1:pe_pkg::DATA_W];
            endcase
        end
    end

    // One cycle behind the comparison
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mti_q <= 1'b0;
        end else begin
            mti_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mti_o = mti_q;

endmodule

// File: logic/pe_plic.sv
`timescale 1ns/1ps

module pe_plic (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        en_i,
    input  logic                        we_i,
    input  pe_pkg::plic_reg_e           reg_i,
    input  logic [pe_pkg::DATA_W-1:0]   data_i,
    output logic [pe_pkg::DATA_W-1:0]   data_o,

    // Level source in, machine external interrupt out
    input  logic                        irq_i,
    output logic                        irq_o
);

    logic pending_q;
    logic enable_q;
    logic gate_open_q;
    logic claim;
    logic complete;

    ////////////////////////////////////////////////////////////////////////////
    // Gateway
    ////////////////////////////////////////////////////////////////////////////

    // Claim only succeeds on an enabled, pending source
    assign claim    = en_i && !we_i && (reg_i == pe_pkg::PLIC_CLAIM) && pending_q && enable_q;
    assign complete = en_i && we_i && (reg_i == pe_pkg::PLIC_CLAIM);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q   <= 1'b0;
            gate_open_q <= 1'b1;
        end else begin
            if (claim) begin
                pending_q   <= 1'b0;
                gate_open_q <= 1'b0;
            end else begin
                if (irq_i && gate_open_q) begin
                    pending_q <= 1'b1;
                end
                // Completion lets the still-high level back in
                if (complete) begin
                    gate_open_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (en_i && we_i && (reg_i == pe_pkg::PLIC_ENABLE)) begin
            enable_q <= data_i[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data and interrupt
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (reg_i)
                pe_pkg::PLIC_PENDING: data_o <= {{(pe_pkg::DATA_W-1){1'b0}}, pending_q};
                pe_pkg::PLIC_ENABLE:  data_o <= {{(pe_pkg::DATA_W-1){1'b0}}, enable_q};
                pe_pkg::PLIC_CLAIM:   data_o <= (pending_q && enable_q) ? pe_pkg::PLIC_SRC_ID : '0;
                default:              data_o <= '0;
            endcase
        end
    end

    assign irq_o = pending_q && enable_q;

endmodule

// File: logic/pe_periph_top.sv
`timescale 1ns/1ps

module pe_periph_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    // Wishbone classic slave port
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [pe_pkg::SEL_W-1:0]         wb_sel_i,
    input  logic [pe_pkg::ADDR_W-1:0]        wb_adr_i,
    input  logic [pe_pkg::DATA_W-1:0]        wb_dat_i,
    output logic [pe_pkg::DATA_W-1:0]        wb_dat_o,
    output logic                             wb_ack_o,

    // External synchronous data memory
    output logic                             dmem_en_o,
    output logic [pe_pkg::SEL_W-1:0]         dmem_we_o,
    output logic [pe_pkg::DMEM_ADDR_W-1:0]   dmem_addr_o,
    input  logic [pe_pkg::DATA_W-1:0]        dmem_data_i,
    output logic [pe_pkg::DATA_W-1:0]        dmem_data_o,

    // Interrupts
    input  logic                             ext_irq_i,
    output logic                             mti_o,
    output logic                             mei_o
);

    logic                       rtc_en;
    logic                       plic_en;
    logic [pe_pkg::DATA_W-1:0]  rtc_rdata;
    logic [pe_pkg::DATA_W-1:0]  plic_rdata;

    // Write data goes to memory untouched
    assign dmem_data_o = wb_dat_i;

    pe_bus_decoder u_decoder (
        .clk_i        (clk_i      ),
        .rst_ni       (rst_ni     ),
        .wb_cyc_i     (wb_cyc_i   ),
        .wb_stb_i     (wb_stb_i   ),
        .wb_we_i      (wb_we_i    ),
        .wb_sel_i     (wb_sel_i   ),
        .wb_adr_i     (wb_adr_i   ),
        .wb_ack_o     (wb_ack_o   ),
        .wb_dat_o     (wb_dat_o   ),
        .rtc_en_o     (rtc_en     ),
        .plic_en_o    (plic_en    ),
        .rtc_rdata_i  (rtc_rdata  ),
        .plic_rdata_i (plic_rdata ),
        .dmem_en_o    (dmem_en_o  ),
        .dmem_we_o    (dmem_we_o  ),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_data_i  (dmem_data_i)
    );

    // Register offset is the word index within the region
    pe_rtc u_rtc (
        .clk_i  (clk_i                               ),
        .rst_ni (rst_ni                              ),
        .en_i   (rtc_en                              ),
        .we_i   (wb_we_i                             ),
        .sel_i  (wb_sel_i                            ),
        .reg_i  (pe_pkg::rtc_reg_e'(wb_adr_i[3:2])   ),
        .data_i (wb_dat_i                            ),
        .data_o (rtc_rdata                           ),
        .mti_o  (mti_o                               )
    );

    pe_plic u_plic (
        .clk_i  (clk_i                               ),
        .rst_ni (rst_ni                              ),
        .en_i   (plic_en                             ),
        .we_i   (wb_we_i                             ),
        .reg_i  (pe_pkg::plic_reg_e'(wb_adr_i[3:2])  ),
        .data_i (wb_dat_i                            ),
        .data_o (plic_rdata                          ),
        .irq_i  (ext_irq_i                           ),
        .irq_o  (mei_o                               )
    );

endmodule

// File: tests/pe_periph_asserts.sv
`timescale 1ns/1ps

module pe_periph_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic dmem_en_o
);

    int unsigned assert_errors = 0;
    logic        accept;

    // Same acceptance rule as the slave
    assign accept = wb_cyc_i && wb_stb_i && !wb_ack_o;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone and memory strobe properties
    ////////////////////////////////////////////////////////////////////////////

    ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else begin
        assert_errors++;
        $error("ack high without cyc and stb");
    end

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_o |=> !wb_ack_o)
    else begin
        assert_errors++;
        $error("ack high for two cycles in a row");
    end

    ack_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |=> wb_ack_o)
    else begin
        assert_errors++;
        $error("no ack one cycle after acceptance");
    end

    dmem_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmem_en_o |=> !dmem_en_o)
    else begin
        assert_errors++;
        $error("dmem_en_o longer than one cycle");
    end

endmodule

bind pe_periph_top pe_periph_asserts u_asserts (.*);

// File: tests/tb_pe_periph.sv
`timescale 1ns/1ps

module tb_pe_periph;

    localparam int unsigned TIMEOUT = 64;
    localparam int unsigned N_DMEM  = 16;

    logic                             clk_i;
    logic                             rst_ni;
    logic                             wb_cyc_i;
    logic                             wb_stb_i;
    logic                             wb_we_i;
    logic [pe_pkg::SEL_W-1:0]         wb_sel_i;
    logic [pe_pkg::ADDR_W-1:0]        wb_adr_i;
    logic [pe_pkg::DATA_W-1:0]        wb_dat_i;
    logic [pe_pkg::DATA_W-1:0]        wb_dat_o;
    logic                             wb_ack_o;
    logic                             dmem_en_o;
    logic [pe_pkg::SEL_W-1:0]         dmem_we_o;
    logic [pe_pkg::DMEM_ADDR_W-1:0]   dmem_addr_o;
    logic [pe_pkg::DATA_W-1:0]        dmem_data_i;
    logic [pe_pkg::DATA_W-1:0]        dmem_data_o;
    logic                             ext_irq_i;
    logic                             mti_o;
    logic                             mei_o;

    // Memory model, its shadow copy and the peripheral model state
    logic [pe_pkg::DATA_W-1:0]        mem [256];
    logic [pe_pkg::DATA_W-1:0]        shadow_mem [256];
    logic [2*pe_pkg::DATA_W-1:0]      shadow_cmp;
    logic                             model_pending;
    logic                             model_enable;
    logic                             check_armed;
    integer                           seed;
    int unsigned                      data_errors;
    int unsigned                      flag_errors;
    int unsigned                      timeout_errors;

    pe_periph_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte-writable data memory with one-cycle read
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (dmem_en_o) begin
            for (int b = 0; b < pe_pkg::SEL_W; b++) begin
                if (dmem_we_o[b]) begin
                    mem[dmem_addr_o[9:2]][b*8 +: 8] <= dmem_data_o[b*8 +: 8];
                end
            end
            dmem_data_i <= mem[dmem_addr_o[9:2]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference and checks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [pe_pkg::ADDR_W-1:0] reg_addr(input pe_pkg::region_e region,
                                                          input logic [1:0] offset);
        return {region, 20'd0, offset, 2'b00};
    endfunction

    // Expected read data, built from shadow state only
    function automatic logic [pe_pkg::DATA_W-1:0] expected_read(
        input logic [pe_pkg::ADDR_W-1:0] adr
    );
        logic [1:0] offset;
        offset = adr[3:2];
        case (adr[pe_pkg::ADDR_W-1:pe_pkg::REGION_LSB])
            pe_pkg::REGION_DMEM: return shadow_mem[adr[9:2]];
            pe_pkg::REGION_RTC:
                return (offset == pe_pkg::RTC_MTIMECMP_HI) ? shadow_cmp[63:32] : shadow_cmp[31:0];
            pe_pkg::REGION_PLIC: begin
                case (offset)
                    pe_pkg::PLIC_PENDING: return {31'd0, model_pending};
                    pe_pkg::PLIC_ENABLE:  return {31'd0, model_enable};
                    pe_pkg::PLIC_CLAIM:
                        return (model_pending && model_enable) ? pe_pkg::PLIC_SRC_ID : '0;
                    default:              return '0;
                endcase
            end
            // Unmapped
            default: return '0;
        endcase
    endfunction

    task automatic check_data(input string name, input logic [pe_pkg::DATA_W-1:0] got,
                              input logic [pe_pkg::DATA_W-1:0] expected);
        if (got !== expected) begin
            data_errors++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // Armed reads are compared in their ack cycle
    always @(negedge clk_i) begin
        if (wb_ack_o && check_armed) begin
            check_data("wb_dat_o", wb_dat_o, expected_read(wb_adr_i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus master
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [pe_pkg::ADDR_W-1:0] adr,
                             input logic [pe_pkg::DATA_W-1:0] dat,
                             input logic [pe_pkg::SEL_W-1:0] sel,
                             output logic [pe_pkg::DATA_W-1:0] rdata);
        int n;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        // The memory strobe is visible in the acceptance cycle
        @(negedge clk_i);
        check_flag("dmem_en_o", dmem_en_o, adr[31:24] == pe_pkg::REGION_DMEM);
        if (dmem_en_o) begin
            check_data("dmem_addr_o", {8'd0, dmem_addr_o}, {8'd0, adr[23:0]});
            check_data("dmem_we_o", {28'd0, dmem_we_o}, {28'd0, we ? sel : 4'd0});
            if (we) begin
                check_data("dmem_data_o", dmem_data_o, dat);
            end
        end
        n = 1;
        while (!wb_ack_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        rdata = wb_dat_o;
        if (!wb_ack_o) begin
            timeout_errors++;
            $display("Timed out waiting for ack at address 0x%08h", adr);
        end else begin
            check_data("wb_ack_o latency", n, 2);
        end
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic wb_write(input logic [pe_pkg::ADDR_W-1:0] adr,
                            input logic [pe_pkg::DATA_W-1:0] dat,
                            input logic [pe_pkg::SEL_W-1:0] sel);
        logic [pe_pkg::DATA_W-1:0] discard;
        bus_cycle(1'b1, adr, dat, sel, discard);
        for (int b = 0; b < pe_pkg::SEL_W; b++) begin
            if (sel[b] && adr[31:24] == pe_pkg::REGION_DMEM) begin
                shadow_mem[adr[9:2]][b*8 +: 8] = dat[b*8 +: 8];
            end
            if (sel[b] && adr[31:24] == pe_pkg::REGION_RTC && adr[3]) begin
                shadow_cmp[(adr[2] ? 32 : 0) + b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        if (adr == reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_ENABLE)) begin
            model_enable = dat[0];
        end
    endtask

    task automatic wb_read(input logic [pe_pkg::ADDR_W-1:0] adr, input logic checked,
                           output logic [pe_pkg::DATA_W-1:0] rdata);
        check_armed = checked;
        bus_cycle(1'b0, adr, '0, '0, rdata);
        check_armed = 1'b0;
    endtask

    task automatic wait_mti(input logic expected);
        int n;
        n = 0;
        @(negedge clk_i);
        while (mti_o !== expected && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (mti_o !== expected) begin
            timeout_errors++;
            $display("Timed out waiting for mti_o to become %0b", expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [pe_pkg::ADDR_W-1:0] adr;
        logic [pe_pkg::DATA_W-1:0] rnd;
        logic [pe_pkg::DATA_W-1:0] rdata;
        logic [pe_pkg::DATA_W-1:0] t0;
        logic [pe_pkg::DATA_W-1:0] t1;
        int unsigned               total;
        seed           = 32'h08b3c0af;
        data_errors    = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        check_armed    = 1'b0;
        model_pending  = 1'b0;
        model_enable   = 1'b0;
        shadow_cmp     = pe_pkg::MTIMECMP_RESET;
        rst_ni      <= 1'b0;
        wb_cyc_i    <= 1'b0;
        wb_stb_i    <= 1'b0;
        wb_we_i     <= 1'b0;
        wb_sel_i    <= '0;
        wb_adr_i    <= '0;
        wb_dat_i    <= '0;
        dmem_data_i <= '0;
        ext_irq_i   <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i]        <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
            shadow_mem[i]  = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        // Idle outputs stay low for a few cycles after reset
        repeat (4) begin
            @(negedge clk_i);
            check_flag("mti_o", mti_o, 1'b0);
            check_flag("mei_o", mei_o, 1'b0);
            check_flag("wb_ack_o", wb_ack_o, 1'b0);
        end

        // Random memory writes with read-back
        repeat (N_DMEM) begin
            rnd = $random(seed);
            adr = {pe_pkg::REGION_DMEM, 14'd0, rnd[7:0], 2'b00};
            wb_write(adr, $random(seed), $random(seed));
            wb_read(adr, 1'b1, rdata);
        end

        // Unmapped codes read zero
        for (int k = 0; k < 4; k++) begin
            adr = {8'(k * 16), 24'h000010};
            wb_write(adr, $random(seed), 4'hf);
            wb_read(adr, 1'b1, rdata);
        end

        // mtime runs and mtimecmp halves keep byte writes
        wb_read(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIME_LO), 1'b0, t0);
        wb_read(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIME_LO), 1'b0, t1);
        check_flag("mtime increasing", t1 > t0, 1'b1);
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_LO), $random(seed),
                 $random(seed));
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI), $random(seed),
                 $random(seed));
        wb_read(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_LO), 1'b1, rdata);
        wb_read(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI), 1'b1, rdata);

        // Compare just ahead of mtime, then back to all ones
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI), '1, 4'hf);
        wb_read(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIME_LO), 1'b0, t0);
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_LO), t0 + 32, 4'hf);
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI), '0, 4'hf);
        @(negedge clk_i);
        check_flag("mti_o", mti_o, 1'b0);
        wait_mti(1'b1);
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_LO), '1, 4'hf);
        wb_write(reg_addr(pe_pkg::REGION_RTC, pe_pkg::RTC_MTIMECMP_HI), '1, 4'hf);
        wait_mti(1'b0);

        // PLIC gateway, enable, claim and complete
        @(posedge clk_i);
        ext_irq_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        model_pending = 1'b1;
        wb_read(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_PENDING), 1'b1, rdata);
        @(negedge clk_i);
        check_flag("mei_o", mei_o, 1'b0);
        wb_write(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_ENABLE), 32'h1, 4'hf);
        @(negedge clk_i);
        check_flag("mei_o", mei_o, 1'b1);
        wb_read(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_CLAIM), 1'b1, rdata);
        model_pending = 1'b0;
        @(negedge clk_i);
        check_flag("mei_o", mei_o, 1'b0);
        // Gateway is closed so nothing is left to claim
        wb_read(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_CLAIM), 1'b1, rdata);
        wb_write(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_CLAIM), pe_pkg::PLIC_SRC_ID, 4'hf);
        model_pending = 1'b1;
        wb_read(reg_addr(pe_pkg::REGION_PLIC, pe_pkg::PLIC_PENDING), 1'b1, rdata);
        @(negedge clk_i);
        check_flag("mei_o", mei_o, 1'b1);

        total = data_errors + flag_errors + timeout_errors + dut_i.u_asserts.assert_errors;
        $display("Errors: data %0d, flag %0d, timeout %0d, assertion %0d", data_errors,
                 flag_errors, timeout_errors, dut_i.u_asserts.assert_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/pe_pkg.sv
logic/pe_bus_decoder.sv
logic/pe_rtc.sv
logic/pe_plic.sv
logic/pe_periph_top.sv
tests/pe_periph_asserts.sv
tests/tb_pe_periph.sv

// File: Bender.yml
package:
  name: pe_periph

sources:
  - logic/pe_pkg.sv
  - logic/pe_bus_decoder.sv
  - logic/pe_rtc.sv
  - logic/pe_plic.sv
  - logic/pe_periph_top.sv
  - target: test
    files:
      - tests/pe_periph_asserts.sv
      - tests/tb_pe_periph.sv
